/* test/decoder_stim.txt */
# instr a_sel b_sel alu_op mem_req mem_we mem_size gpr_we wb_sel branch jal jalr illegal
# all columns hex, a comment line ends a group and adds idle cycles
# OP
003100b3 0 0 00 0 0 0 1 0 0 0 0 0
403100b3 0 0 08 0 0 0 1 0 0 0 0 0
003110b3 0 0 01 0 0 0 1 0 0 0 0 0
003120b3 0 0 02 0 0 0 1 0 0 0 0 0
003130b3 0 0 03 0 0 0 1 0 0 0 0 0
003140b3 0 0 04 0 0 0 1 0 0 0 0 0
003150b3 0 0 05 0 0 0 1 0 0 0 0 0
403150b3 0 0 0d 0 0 0 1 0 0 0 0 0
003160b3 0 0 06 0 0 0 1 0 0 0 0 0
003170b3 0 0 07 0 0 0 1 0 0 0 0 0
# OP_IMM
00510093 0 1 00 0 0 0 1 0 0 0 0 0
00512093 0 1 02 0 0 0 1 0 0 0 0 0
00513093 0 1 03 0 0 0 1 0 0 0 0 0
00514093 0 1 04 0 0 0 1 0 0 0 0 0
00516093 0 1 06 0 0 0 1 0 0 0 0 0
fff17093 0 1 07 0 0 0 1 0 0 0 0 0
00511093 0 1 01 0 0 0 1 0 0 0 0 0
00515093 0 1 05 0 0 0 1 0 0 0 0 0
40515093 0 1 0d 0 0 0 1 0 0 0 0 0
# BRANCH
00310063 0 0 18 0 0 0 0 0 1 0 0 0
00311063 0 0 19 0 0 0 0 0 1 0 0 0
00314063 0 0 1c 0 0 0 0 0 1 0 0 0
00315063 0 0 1d 0 0 0 0 0 1 0 0 0
00316063 0 0 1e 0 0 0 0 0 1 0 0 0
00317063 0 0 1f 0 0 0 0 0 1 0 0 0
# loads and stores
00410083 0 1 00 1 0 0 1 1 0 0 0 0
00411083 0 1 00 1 0 1 1 1 0 0 0 0
00412083 0 1 00 1 0 2 1 1 0 0 0 0
00414083 0 1 00 1 0 4 1 1 0 0 0 0
00415083 0 1 00 1 0 5 1 1 0 0 0 0
00310223 0 3 00 1 1 0 0 0 0 0 0 0
00311223 0 3 00 1 1 1 0 0 0 0 0 0
00312223 0 3 00 1 1 2 0 0 0 0 0 0
# LUI, AUIPC, JAL, JALR, FENCE
123450b7 2 2 00 0 0 0 1 0 0 0 0 0
12345097 1 2 00 0 0 0 1 0 0 0 0 0
000000ef 1 4 00 0 0 0 1 0 0 1 0 0
000100e7 1 4 00 0 0 0 1 0 0 0 1 0
0ff0000f 0 0 00 0 0 0 0 0 0 0 0 0
# illegal encodings
023100b3 0 0 00 0 0 0 0 0 0 0 0 1
403110b3 0 0 00 0 0 0 0 0 0 0 0 1
40511093 0 0 00 0 0 0 0 0 0 0 0 1
00312063 0 0 00 0 0 0 0 0 0 0 0 1
00413083 0 0 00 0 0 0 0 0 0 0 0 1
00314223 0 0 00 0 0 0 0 0 0 0 0 1
00315223 0 0 00 0 0 0 0 0 0 0 0 1
000110e7 0 0 00 0 0 0 0 0 0 0 0 1
0000100f 0 0 00 0 0 0 0 0 0 0 0 1
00000073 0 0 00 0 0 0 0 0 0 0 0 1
300110f3 0 0 00 0 0 0 0 0 0 0 0 1
003100b1 0 0 00 0 0 0 0 0 0 0 0 1
0000000b 0 0 00 0 0 0 0 0 0 0 0 1

/* vlog.f */
+incdir+design
design/decoder_pkg.sv
design/alu_op_decoder.sv
design/lsu_size_decoder.sv
design/main_decoder.sv
design/decode_stage_reg.sv
design/decoder_riscv.sv
test/tb_clk_gen.sv
test/decode_checker.sv
test/tb_decoder_riscv.sv

/* Bender.yml */
package:
  name: decoder_riscv

sources:
  - include_dirs:
      - design
    files:
      - design/decoder_pkg.sv
      - design/alu_op_decoder.sv
      - design/lsu_size_decoder.sv
      - design/main_decoder.sv
      - design/decode_stage_reg.sv
      - design/decoder_riscv.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/decode_checker.sv
      - test/tb_decoder_riscv.sv

/* test/tb_decoder_riscv.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decoder_riscv
  import decoder_pkg::*;
();

  logic             clk;
  logic             arst_n;
  instr_t           instr;
  logic             instr_valid;
  decode_ctrl_t     ctrl;
  logic             ctrl_valid;
  int               mismatch_cnt;
  int               protocol_cnt;
  int               pending;
  int               tb_err_cnt;
  int               fd;
  int               code;
  int               cycles;
  logic [31:0]      col [13];
  logic [8*256-1:0] skipped;    // rest of a comment line
  decode_ctrl_t     exp;
  logic             at_eof;

  tb_clk_gen u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  decoder_riscv uut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .instr_i       (instr),
    .instr_valid_i (instr_valid),
    .ctrl_o        (ctrl),
    .ctrl_valid_o  (ctrl_valid)
  );

  decode_checker u_chk (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .instr_valid_i  (instr_valid),
    .ctrl_valid_i   (ctrl_valid),
    .ctrl_i         (ctrl),
    .mismatch_cnt_o (mismatch_cnt),
    .protocol_cnt_o (protocol_cnt),
    .pending_o      (pending)
  );

  task automatic idle_gap();
    int len;
    len = 1 + ($urandom % 4);
    repeat (len) begin
      @(posedge clk);
      instr_valid <= 1'b0;
      instr       <= $urandom;   // junk, must not reach ctrl_o
    end
  endtask

  task automatic drive_line();
    exp.a_sel    = a_sel_e'(col[1][1:0]);
    exp.b_sel    = b_sel_e'(col[2][2:0]);
    exp.alu_op   = alu_op_e'(col[3][4:0]);
    exp.mem_req  = col[4][0];
    exp.mem_we   = col[5][0];
    exp.mem_size = mem_size_e'(col[6][2:0]);
    exp.gpr_we   = col[7][0];
    exp.wb_sel   = wb_sel_e'(col[8][1:0]);
    exp.branch   = col[9][0];
    exp.jal      = col[10][0];
    exp.jalr     = col[11][0];
    exp.illegal  = col[12][0];
    @(posedge clk);
    instr       <= col[0];
    instr_valid <= 1'b1;
    u_chk.push_expected(col[0], exp);
  endtask

  initial begin
    instr       = '0;
    instr_valid = 1'b0;
    tb_err_cnt  = 0;
    at_eof      = 1'b0;
    void'($urandom(32'h841f3b6e));

    cycles = 0;
    while (arst_n !== 1'b1 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (arst_n !== 1'b1) begin
      $display("ERROR: reset was never released");
      tb_err_cnt++;
    end

    fd = $fopen("test/decoder_stim.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open test/decoder_stim.txt");
      tb_err_cnt++;
      at_eof = 1'b1;
    end
    while (!at_eof) begin
      code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                     col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                     col[7], col[8], col[9], col[10], col[11], col[12]);
      if (code == 13) begin
        drive_line();
      end else if (code == 0) begin
        // a comment line closes the running group
        if ($fgets(skipped, fd) == 0) begin
          at_eof = 1'b1;
        end else begin
          idle_gap();
        end
      end else begin
        if (code != -1) begin
          $display("ERROR: malformed line in the stim file");
          tb_err_cnt++;
        end
        at_eof = 1'b1;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    @(posedge clk);
    instr_valid <= 1'b0;

    cycles = 0;
    while (pending != 0 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    repeat (2) @(posedge clk);   // a few more hold checks
    if (pending != 0) begin
      $display("ERROR: %0d expected results never came out of the DUT", pending);
      tb_err_cnt++;
    end

    $display("errors: %0d mismatch, %0d protocol, %0d testbench",
             mismatch_cnt, protocol_cnt, tb_err_cnt);
    if (mismatch_cnt + protocol_cnt + tb_err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/decode_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_checker
  import decoder_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         instr_valid_i,   // strobe as the DUT samples it
  input  logic         ctrl_valid_i,
  input  decode_ctrl_t ctrl_i,
  output int           mismatch_cnt_o,
  output int           protocol_cnt_o,
  output int           pending_o
);

  decode_ctrl_t exp_q[$];
  instr_t       instr_q[$];
  decode_ctrl_t held;        // last bundle out of the stage
  decode_ctrl_t exp_now;
  instr_t       cur_instr;
  logic         strobe_seen;

  initial begin
    mismatch_cnt_o = 0;
    protocol_cnt_o = 0;
    pending_o      = 0;
    cur_instr      = '0;
  end

  task automatic push_expected(input instr_t instr, input decode_ctrl_t exp);
    instr_q.push_back(instr);
    exp_q.push_back(exp);
    pending_o = exp_q.size();
  endtask

  task automatic compare_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED %s instr %h expected %h actual %h",
               name, cur_instr, exp_v, act_v);
      mismatch_cnt_o++;
    end
  endtask

  task automatic compare_bundle(input decode_ctrl_t exp);
    compare_field("ctrl_o.a_sel", exp.a_sel, ctrl_i.a_sel);
    compare_field("ctrl_o.b_sel", exp.b_sel, ctrl_i.b_sel);
    compare_field("ctrl_o.alu_op", exp.alu_op, ctrl_i.alu_op);
    compare_field("ctrl_o.mem_req", exp.mem_req, ctrl_i.mem_req);
    compare_field("ctrl_o.mem_we", exp.mem_we, ctrl_i.mem_we);
    compare_field("ctrl_o.mem_size", exp.mem_size, ctrl_i.mem_size);
    compare_field("ctrl_o.gpr_we", exp.gpr_we, ctrl_i.gpr_we);
    compare_field("ctrl_o.wb_sel", exp.wb_sel, ctrl_i.wb_sel);
    compare_field("ctrl_o.branch", exp.branch, ctrl_i.branch);
    compare_field("ctrl_o.jal", exp.jal, ctrl_i.jal);
    compare_field("ctrl_o.jalr", exp.jalr, ctrl_i.jalr);
    compare_field("ctrl_o.illegal", exp.illegal, ctrl_i.illegal);
  endtask

  // same edge on which the stage register loads
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      strobe_seen <= 1'b0;
    end else begin
      strobe_seen <= instr_valid_i;
    end
  end

  // outputs are settled mid-cycle
  always @(negedge clk_i) begin
    if (!arst_n_i) begin
      held         = '0;     // RS1, RS2, ADD, B and EX_RESULT all encode as 0
      held.illegal = 1'b1;
    end else begin
      compare_field("ctrl_valid_o", strobe_seen, ctrl_valid_i);
      if (ctrl_valid_i === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: ctrl_valid_o high with no expected result queued");
          protocol_cnt_o++;
        end else begin
          cur_instr = instr_q.pop_front();
          exp_now   = exp_q.pop_front();
          pending_o = exp_q.size();
          compare_bundle(exp_now);
          held = exp_now;
        end
      end else begin
        compare_field("ctrl_o", held, ctrl_i);   // must hold while idle
      end
    end
  end

endmodule

`default_nettype wire

/* test/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;   // 10 ns period
  end

  // held low for 4 cycles, released away from the active edge
  initial begin
    arst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* design/decoder_riscv.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder_riscv
  import decoder_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  instr_t       instr_i,
  input  logic         instr_valid_i,   // one-cycle strobe
  output decode_ctrl_t ctrl_o,
  output logic         ctrl_valid_o
);

  decode_ctrl_t ctrl_comb;  // decode result, same cycle

  main_decoder u_main_dec (
    .instr_i (instr_i),
    .ctrl_o  (ctrl_comb)
  );

  // into execute stage
  decode_stage_reg u_stage_reg (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (instr_valid_i),
    .ctrl_i   (ctrl_comb),
    .valid_o  (ctrl_valid_o),
    .ctrl_o   (ctrl_o)
  );

endmodule

`default_nettype wire

/* design/decode_stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_reg
  import decoder_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         valid_i,
  input  decode_ctrl_t ctrl_i,
  output logic         valid_o,
  output decode_ctrl_t ctrl_o
);

  // one strobe in, one valid cycle out
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // bundle holds between strobes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_o <= CTRL_ILLEGAL;
    end else if (valid_i) begin
      ctrl_o <= ctrl_i;
    end
  end

endmodule

`default_nettype wire

/* design/main_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module main_decoder
  import decoder_pkg::*;
(
  input  instr_t       instr_i,
  output decode_ctrl_t ctrl_o
);

  opcode_e      opcode;
  funct3_t      funct3;
  funct7_t      funct7;
  alu_op_e      alu_op;
  logic         alu_legal;
  mem_size_e    mem_size;
  logic         size_legal;
  logic         opc_legal;
  logic         illegal;
  decode_ctrl_t ctrl_d;

  assign opcode = opcode_e'(instr_i[6:2]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  alu_op_decoder u_alu_op_dec (
    .opcode_i (opcode),
    .funct3_i (funct3),
    .funct7_i (funct7),
    .alu_op_o (alu_op),
    .legal_o  (alu_legal)
  );

  lsu_size_decoder u_lsu_size_dec (
    .is_store_i (opcode == STORE),
    .funct3_i   (funct3),
    .mem_size_o (mem_size),
    .legal_o    (size_legal)
  );

  always_comb begin
    ctrl_d         = CTRL_ILLEGAL;
    ctrl_d.illegal = 1'b0;
    ctrl_d.alu_op  = alu_op;     // ADD outside OP/OP_IMM/BRANCH
    opc_legal      = 1'b1;

    case (opcode)
      OP: begin
        ctrl_d.gpr_we = 1'b1;
      end
      OP_IMM: begin
        ctrl_d.b_sel  = IMM_I;
        ctrl_d.gpr_we = 1'b1;
      end
      LOAD: begin
        ctrl_d.b_sel    = IMM_I;
        ctrl_d.mem_req  = 1'b1;
        ctrl_d.mem_size = mem_size;
        ctrl_d.wb_sel   = LSU_DATA;
        ctrl_d.gpr_we   = 1'b1;
      end
      STORE: begin
        ctrl_d.b_sel    = IMM_S;
        ctrl_d.mem_req  = 1'b1;
        ctrl_d.mem_we   = 1'b1;
        ctrl_d.mem_size = mem_size;
      end
      LUI: begin
        ctrl_d.a_sel  = ZERO;    // 0 + imm_u
        ctrl_d.b_sel  = IMM_U;
        ctrl_d.gpr_we = 1'b1;
      end
      AUIPC: begin
        ctrl_d.a_sel  = CURR_PC;
        ctrl_d.b_sel  = IMM_U;
        ctrl_d.gpr_we = 1'b1;
      end
      JAL: begin
        ctrl_d.a_sel  = CURR_PC; // link = pc + 4
        ctrl_d.b_sel  = INCR;
        ctrl_d.gpr_we = 1'b1;
        ctrl_d.jal    = 1'b1;
      end
      JALR: begin
        ctrl_d.a_sel  = CURR_PC;
        ctrl_d.b_sel  = INCR;
        ctrl_d.gpr_we = 1'b1;
        ctrl_d.jalr   = 1'b1;
        opc_legal     = (funct3 == 3'b000);
      end
      BRANCH: begin
        ctrl_d.branch = 1'b1;
      end
      MISC_MEM: begin
        opc_legal = (funct3 == 3'b000);  // fence, no-op here
      end
      default: opc_legal = 1'b0;         // SYSTEM and unknown
    endcase
  end

  // size check only counts for memory ops
  assign illegal = (instr_i[1:0] != 2'b11)
                 || !opc_legal
                 || !alu_legal
                 || (ctrl_d.mem_req && !size_legal);

  assign ctrl_o = illegal ? CTRL_ILLEGAL : ctrl_d;

endmodule

`default_nettype wire

/* design/lsu_size_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_size_decoder
  import decoder_pkg::*;
(
  input  logic      is_store_i,
  input  funct3_t   funct3_i,
  output mem_size_e mem_size_o,
  output logic      legal_o
);

  always_comb begin
    mem_size_o = B;
    legal_o    = 1'b1;

    case (funct3_i)
      3'b000: mem_size_o = B;
      3'b001: mem_size_o = H;
      3'b010: mem_size_o = W;
      3'b100: begin
        mem_size_o = BU;
        legal_o    = !is_store_i;   // no unsigned stores
      end
      3'b101: begin
        mem_size_o = HU;
        legal_o    = !is_store_i;
      end
      default: legal_o = 1'b0;
    endcase

    if (!legal_o) begin
      mem_size_o = B;
    end
  end

endmodule

`default_nettype wire

/* design/alu_op_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_op_decoder
  import decoder_pkg::*;
(
  input  opcode_e opcode_i,
  input  funct3_t funct3_i,
  input  funct7_t funct7_i,
  output alu_op_e alu_op_o,
  output logic    legal_o    // encoding exists for this opcode
);

  localparam funct7_t F7_BASE = 7'h00;
  localparam funct7_t F7_ALT  = 7'h20;  // SUB / SRA variant

  // funct3 map shared by OP and OP_IMM
  function automatic alu_op_e base_op(funct3_t f3);
    alu_op_e op;
    op = ADD;
    case (f3)
      3'b000:  op = ADD;
      3'b001:  op = SLL;
      3'b010:  op = SLTS;
      3'b011:  op = SLTU;
      3'b100:  op = XOR;
      3'b101:  op = SRL;
      3'b110:  op = OR;
      3'b111:  op = AND;
      default: op = ADD;
    endcase
    return op;
  endfunction

  always_comb begin
    alu_op_o = ADD;
    legal_o  = 1'b1;

    case (opcode_i)
      OP: begin
        if (funct7_i == F7_BASE) begin
          alu_op_o = base_op(funct3_i);
        end else if (funct7_i == F7_ALT && funct3_i == 3'b000) begin
          alu_op_o = SUB;
        end else if (funct7_i == F7_ALT && funct3_i == 3'b101) begin
          alu_op_o = SRA;
        end else begin
          legal_o = 1'b0;
        end
      end

      OP_IMM: begin
        case (funct3_i)
          3'b001: begin       // slli, shamt only
            alu_op_o = SLL;
            legal_o  = (funct7_i == F7_BASE);
          end
          3'b101: begin
            if (funct7_i == F7_BASE) begin
              alu_op_o = SRL;
            end else if (funct7_i == F7_ALT) begin
              alu_op_o = SRA;
            end else begin
              legal_o = 1'b0;
            end
          end
          default: alu_op_o = base_op(funct3_i);  // imm in funct7 bits
        endcase
      end

      BRANCH: begin
        case (funct3_i)
          3'b000:  alu_op_o = EQ;
          3'b001:  alu_op_o = NE;
          3'b100:  alu_op_o = LTS;
          3'b101:  alu_op_o = GES;
          3'b110:  alu_op_o = LTU;
          3'b111:  alu_op_o = GEU;
          default: legal_o  = 1'b0;   // 010, 011 undefined
        endcase
      end

      default: ;  // address / link adds
    endcase

    if (!legal_o) begin
      alu_op_o = ADD;
    end
  end

endmodule

`default_nettype wire

/* design/decoder_pkg.sv */
`default_nettype none

`include "decoder_cfg.svh"

package decoder_pkg;

  typedef logic [`DEC_INSTR_W-1:0]  instr_t;
  typedef logic [`DEC_FUNCT3_W-1:0] funct3_t;
  typedef logic [`DEC_FUNCT7_W-1:0] funct7_t;

  // instr[6:2], low pair must be 2'b11
  typedef enum logic [`DEC_OPCODE_W-1:0] {
    LOAD     = 5'b00000,
    MISC_MEM = 5'b00011,
    OP_IMM   = 5'b00100,
    AUIPC    = 5'b00101,
    STORE    = 5'b01000,
    OP       = 5'b01100,
    LUI      = 5'b01101,
    BRANCH   = 5'b11000,
    JALR     = 5'b11001,
    JAL      = 5'b11011,
    SYSTEM   = 5'b11100
  } opcode_e;

  // bit 4 marks the comparison group
  typedef enum logic [`DEC_ALU_OP_W-1:0] {
    ADD  = 5'b00000, SUB  = 5'b01000,
    XOR  = 5'b00100, OR   = 5'b00110, AND  = 5'b00111,
    SLL  = 5'b00001, SRL  = 5'b00101, SRA  = 5'b01101,
    SLTS = 5'b00010, SLTU = 5'b00011,
    EQ   = 5'b11000, NE   = 5'b11001,
    LTS  = 5'b11100, GES  = 5'b11101,
    LTU  = 5'b11110, GEU  = 5'b11111
  } alu_op_e;

  typedef enum logic [`DEC_A_SEL_W-1:0] {
    RS1 = 2'd0, CURR_PC = 2'd1, ZERO = 2'd2
  } a_sel_e;

  typedef enum logic [`DEC_B_SEL_W-1:0] {
    RS2 = 3'd0, IMM_I = 3'd1, IMM_U = 3'd2, IMM_S = 3'd3, INCR = 3'd4
  } b_sel_e;

  typedef enum logic [`DEC_WB_SEL_W-1:0] {
    EX_RESULT = 2'd0, LSU_DATA = 2'd1
  } wb_sel_e;

  // funct3 encoding of loads/stores, bit 2 = unsigned
  typedef enum logic [`DEC_MEM_SIZE_W-1:0] {
    B = 3'd0, H = 3'd1, W = 3'd2, BU = 3'd4, HU = 3'd5
  } mem_size_e;

  typedef struct packed {
    a_sel_e    a_sel;
    b_sel_e    b_sel;
    alu_op_e   alu_op;
    logic      mem_req;
    logic      mem_we;
    mem_size_e mem_size;
    logic      gpr_we;
    wb_sel_e   wb_sel;
    logic      branch;
    logic      jal;
    logic      jalr;
    logic      illegal;
  } decode_ctrl_t;

  // all enables off, selects at default
  localparam decode_ctrl_t CTRL_ILLEGAL = '{
    a_sel:    RS1,
    b_sel:    RS2,
    alu_op:   ADD,
    mem_req:  1'b0,
    mem_we:   1'b0,
    mem_size: B,
    gpr_we:   1'b0,
    wb_sel:   EX_RESULT,
    branch:   1'b0,
    jal:      1'b0,
    jalr:     1'b0,
    illegal:  1'b1
  };

endpackage

`default_nettype wire

/* design/decoder_cfg.svh */
`ifndef DECODER_CFG_SVH
`define DECODER_CFG_SVH

// instruction word
`define DEC_INSTR_W     32

// opcode bits above the fixed low pair
`define DEC_OPCODE_W    5

// function fields
`define DEC_FUNCT3_W    3
`define DEC_FUNCT7_W    7

// control bundle fields
`define DEC_ALU_OP_W    5
`define DEC_A_SEL_W     2   // first ALU operand
`define DEC_B_SEL_W     3   // second ALU operand
`define DEC_WB_SEL_W    2   // register file write source
`define DEC_MEM_SIZE_W  3   // load/store access size

`endif
